// ==== common/cipher_pkg.sv ====
// Shared alphabet, types and codes; letters 1..26 map 'a'..'z', 0 is a blank, codes 27..31 unsupported.
package cipher_pkg;

	// Alphabet geometry.
	localparam int LETTER_W = 5;
	localparam int TEXT_LEN = 5;
	localparam int ALPHABET = 26;

	// One letter code.
	typedef logic [LETTER_W-1:0] letter_t;

	// Five letters, letter 1 in the top bits.
	typedef logic [LETTER_W*TEXT_LEN-1:0] text_t;

	// Letter position, 0 to 4.
	typedef logic [2:0] char_index_t;

	// Cipher method select.
	typedef logic [1:0] method_t;

	// Method codes.
	// Code 11 is treated like pass-through.
	localparam method_t METHOD_PASS = 2'b00;
	localparam method_t METHOD_CAESAR = 2'b01;
	localparam method_t METHOD_VIGENERE = 2'b10;

	// Sequencer states.
	// Per letter the FSM walks SELECT, SHIFT, WRITE.
	typedef enum logic [2:0]
	{
		IDLE,
		CAPTURE,
		SELECT,
		SHIFT,
		WRITE,
		DONE
	} seq_state_t;

endpackage

// ==== common/cipher_ctrl_if.sv ====
// Control strobes from sequencer to datapath; all strobes are single-cycle and index is valid while they are high.
`timescale 1ns/1ns

interface cipher_ctrl_if;
	import cipher_pkg::*;

	// Snapshot text, key, decode and method.
	logic capture;
	// Present letter and shift to the shifter.
	logic select;
	// Store shifter result at index.
	logic write;
	// Current letter position.
	char_index_t index;

	// Driving side.
	modport sequencer (
		output capture,
		output select,
		output write,
		output index
	);

	// Receiving side.
	modport datapath (
		input capture,
		input select,
		input write,
		input index
	);

endinterface

// ==== cipher/letter_shifter.sv ====
// Registered modulo-26 letter shift; input letters must be 0..26, shift may be any 5-bit code.
`timescale 1ns/1ns

module letter_shifter (
	input logic clock,
	input logic resetn,
	input cipher_pkg::letter_t letter,
	input cipher_pkg::letter_t shift,
	input logic decode,
	output cipher_pkg::letter_t result
);
	import cipher_pkg::*;

	letter_t shift_mod;
	logic [LETTER_W:0] sum;
	letter_t next_result;

	// Shift reduced modulo the alphabet, so 'z' means no shift.
	always_comb
	begin
		shift_mod = (shift >= letter_t'(ALPHABET)) ? letter_t'(shift - ALPHABET) : shift;
		sum = {1'b0, letter} + {1'b0, shift_mod};
		if (letter == '0)
			next_result = '0; // Blank stays blank.
		else if (decode)
			next_result = (letter > shift_mod) ? letter_t'(letter - shift_mod)
				: letter_t'(letter + ALPHABET - shift_mod);
		else
			next_result = (sum > ALPHABET) ? letter_t'(sum - ALPHABET) : letter_t'(sum);
	end

	// Output register.
	always_ff @(posedge clock)
	begin
		if (!resetn)
			result <= '0;
		else
			result <= next_result;
	end

	// Never leaves the alphabet.
	a_result_range: assert property (@(posedge clock) disable iff (!resetn)
		result <= ALPHABET);

endmodule

// ==== cipher/cipher_datapath.sv ====
// Cipher datapath; inputs are snapshot on capture, so the loader may change during a run.
`timescale 1ns/1ns

module cipher_datapath (
	input logic clock,
	input logic resetn,
	input cipher_pkg::text_t text,
	input cipher_pkg::text_t key,
	input logic decode,
	input cipher_pkg::method_t method,
	cipher_ctrl_if.datapath ctrl,
	output cipher_pkg::text_t text_out
);
	import cipher_pkg::*;

	// Snapshot of the run inputs.
	text_t snap_text;
	text_t snap_key;
	logic snap_decode;
	method_t snap_method;

	// Shifter operands and result.
	letter_t cur_letter;
	letter_t cur_shift;
	letter_t shift_result;

	// Letter at a position, letter 1 on top.
	function automatic letter_t letter_at(text_t t, char_index_t i);
		return t[LETTER_W*(TEXT_LEN-1-i) +: LETTER_W];
	endfunction

	// Text and key snapshot.
	always_ff @(posedge clock)
	begin
		if (ctrl.capture)
		begin
			snap_text <= text;
			snap_key <= key;
		end
	end

	// Control snapshot, operand select and result assembly.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			snap_decode <= 1'b0;
			snap_method <= METHOD_PASS;
			cur_letter <= '0;
			cur_shift <= '0;
			text_out <= '0;
		end
		else
		begin
			if (ctrl.capture)
			begin
				snap_decode <= decode;
				snap_method <= method;
			end
			if (ctrl.select)
			begin
				cur_letter <= letter_at(snap_text, ctrl.index);
				// Caesar reuses key letter 1.
				case (snap_method)
					METHOD_CAESAR: cur_shift <= letter_at(snap_key, '0);
					METHOD_VIGENERE: cur_shift <= letter_at(snap_key, ctrl.index);
					default: cur_shift <= '0;
				endcase
			end
			if (ctrl.write)
				text_out[LETTER_W*(TEXT_LEN-1-ctrl.index) +: LETTER_W] <= shift_result;
		end
	end

	// One-cycle modular shift.
	letter_shifter u_letter_shifter (
		.clock(clock),
		.resetn(resetn),
		.letter(cur_letter),
		.shift(cur_shift),
		.decode(snap_decode),
		.result(shift_result)
	);

endmodule

// ==== cipher/cipher_sequencer.sv ====
// Run sequencer; ack rises 17 clocks after req is sampled and holds until req is seen low.
`timescale 1ns/1ns

module cipher_sequencer (
	input logic clock,
	input logic resetn,
	input logic req,
	output logic ack,
	cipher_ctrl_if.sequencer ctrl
);
	import cipher_pkg::*;

	// Last letter position.
	localparam char_index_t LAST_INDEX = char_index_t'(TEXT_LEN - 1);

	seq_state_t state;
	char_index_t index;

	// Main FSM.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= IDLE;
			index <= '0;
			ack <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Wait for a new request.
					if (req)
						state <= CAPTURE;
				end
				CAPTURE:
				begin
					// Restart at letter 1.
					index <= '0;
					state <= SELECT;
				end
				SELECT:
					state <= SHIFT;
				SHIFT:
					state <= WRITE; // Shifter latency.
				WRITE:
				begin
					// Next letter or finish.
					if (index == LAST_INDEX)
						state <= DONE;
					else
					begin
						index <= index + 3'd1;
						state <= SELECT;
					end
				end
				DONE:
				begin
					// Hold ack while req stays high.
					if (req)
						ack <= 1'b1;
					else
					begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Strobes decoded from state.
	assign ctrl.capture = (state == CAPTURE);
	assign ctrl.select = (state == SELECT);
	assign ctrl.write = (state == WRITE);
	assign ctrl.index = index;

	// Ack belongs to DONE only.
	a_ack_done: assert property (@(posedge clock) disable iff (!resetn)
		ack |-> (state == DONE));

	// Index stays inside the text.
	a_index_range: assert property (@(posedge clock) disable iff (!resetn)
		index < TEXT_LEN);

endmodule

// ==== hdl/text_loader.sv ====
// Text and key letter registers; a sixth strobe wraps and overwrites letter 1, letter contents are not reset.
`timescale 1ns/1ns

module text_loader (
	input logic clock,
	input logic resetn,
	input cipher_pkg::letter_t data_in,
	input logic load_char,
	input logic load_key,
	output cipher_pkg::text_t text,
	output cipher_pkg::text_t key
);
	import cipher_pkg::*;

	// Letter storage, entry 0 is letter 1.
	letter_t text_mem [TEXT_LEN];
	letter_t key_mem [TEXT_LEN];

	// Next write positions.
	char_index_t text_pos;
	char_index_t key_pos;

	// Position counters, wrap 4 to 0.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			text_pos <= '0;
			key_pos <= '0;
		end
		else
		begin
			if (load_char)
				text_pos <= (text_pos == char_index_t'(TEXT_LEN - 1)) ? '0 : text_pos + 3'd1;
			if (load_key)
				key_pos <= (key_pos == char_index_t'(TEXT_LEN - 1)) ? '0 : key_pos + 3'd1;
		end
	end

	// Letter writes.
	always_ff @(posedge clock)
	begin
		if (load_char)
			text_mem[text_pos] <= data_in;
		if (load_key)
			key_mem[key_pos] <= data_in;
	end

	// Pack letters, first letter on top.
	always_comb
	begin
		for (int n = 0; n < TEXT_LEN; n++)
		begin
			text[LETTER_W*(TEXT_LEN-1-n) +: LETTER_W] = text_mem[n];
			key[LETTER_W*(TEXT_LEN-1-n) +: LETTER_W] = key_mem[n];
		end
	end

	// Both counters must stay inside the text.
	a_pos_range: assert property (@(posedge clock) disable iff (!resetn)
		(text_pos < TEXT_LEN) && (key_pos < TEXT_LEN));

endmodule

// ==== hdl/cipher_top.sv ====
// Cipher top level; go is a four-phase req/ack handshake and req may only rise while ack is low.
`timescale 1ns/1ns

module cipher_top (
	input logic clock,
	input logic resetn,
	input cipher_pkg::letter_t data_in,
	input logic load_char,
	input logic load_key,
	input logic decode,
	input cipher_pkg::method_t method,
	input logic req,
	output logic ack,
	output cipher_pkg::text_t text_out
);
	import cipher_pkg::*;

	// Loaded text and key.
	text_t text;
	text_t key;

	// Sequencer to datapath control.
	cipher_ctrl_if ctrl_bus ();

	// User letter registers.
	text_loader u_text_loader (
		.clock(clock),
		.resetn(resetn),
		.data_in(data_in),
		.load_char(load_char),
		.load_key(load_key),
		.text(text),
		.key(key)
	);

	// Handshake and letter walk.
	cipher_sequencer u_cipher_sequencer (
		.clock(clock),
		.resetn(resetn),
		.req(req),
		.ack(ack),
		.ctrl(ctrl_bus.sequencer)
	);

	// Shared cipher engine.
	cipher_datapath u_cipher_datapath (
		.clock(clock),
		.resetn(resetn),
		.text(text),
		.key(key),
		.decode(decode),
		.method(method),
		.ctrl(ctrl_bus.datapath),
		.text_out(text_out)
	);

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and reset; 40 ns period, resetn released 5 ns after the tenth rising edge.
`timescale 1ns/1ns

module tb_clock (
	output logic clock,
	output logic resetn
);

	// Free-running clock.
	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Reset held for ten cycles.
	initial
	begin
		resetn = 1'b0;
		repeat (10) @(posedge clock);
		#5;
		resetn = 1'b1;
	end

endmodule

// ==== bench/cipher_tb.sv ====
// Testbench for cipher_top; reads bench/cipher_stim.txt, so it must run from the project root.
`timescale 1ns/1ns

module cipher_tb;
	import cipher_pkg::*;

	// Six words per vector in the stimulus file.
	localparam int FIELDS = 6;
	localparam int MAX_VECTORS = 64;
	localparam int DRIVE_DELAY = 5;
	// Clocks from the req sampling edge to ack.
	localparam int ACK_CYCLES = 17;
	localparam int ACK_LIMIT = 40;

	logic clock;
	logic resetn;
	letter_t data_in;
	logic load_char;
	logic load_key;
	logic decode;
	method_t method;
	logic req;
	logic ack;
	text_t text_out;

	logic [31:0] stim_mem [FIELDS*MAX_VECTORS];
	int vector_count;
	int error_count;
	int watchdog_cycles;
	int text_pos_model;
	int seed;

	tb_clock u_tb_clock (
		.clock(clock),
		.resetn(resetn)
	);

	cipher_top u_cipher_top (
		.clock(clock),
		.resetn(resetn),
		.data_in(data_in),
		.load_char(load_char),
		.load_key(load_key),
		.decode(decode),
		.method(method),
		.req(req),
		.ack(ack),
		.text_out(text_out)
	);

	// Letter n of a packed text with letter 1 on top.
	function automatic letter_t letter_of(text_t t, int n);
		return t[LETTER_W*(TEXT_LEN-1-n) +: LETTER_W];
	endfunction

	// One-cycle load strobe to text or key.
	task automatic strobe_letter(input logic to_key, input letter_t letter);
		data_in = letter;
		load_char = !to_key;
		load_key = to_key;
		@(posedge clock);
		#DRIVE_DELAY;
		load_char = 1'b0;
		load_key = 1'b0;
		// Track the loader's text position.
		if (!to_key)
			text_pos_model = (text_pos_model + 1) % TEXT_LEN;
	endtask

	// Text, optional sixth letter, then key.
	task automatic load_vector(input text_t text, input text_t key, input letter_t sixth);
		// Pad back to letter 1 after a wrap test.
		while (text_pos_model != 0)
			strobe_letter(1'b0, '0);
		for (int n = 0; n < TEXT_LEN; n++)
			strobe_letter(1'b0, letter_of(text, n));
		// Wraps onto letter 1.
		if (sixth != '0)
			strobe_letter(1'b0, sixth);
		for (int n = 0; n < TEXT_LEN; n++)
			strobe_letter(1'b1, letter_of(key, n));
	endtask

	task automatic check_text_out(input text_t expected, input int vec);
		if (text_out !== expected)
		begin
			$display("FAIL vector %0d text_out expected %h got %h", vec, expected, text_out);
			error_count++;
		end
	endtask

	// Full four-phase run with latency and hold checks.
	task automatic run_and_check(input text_t expected, input int vec);
		int cycles;
		int hold;
		logic ack_seen;
		req = 1'b1;
		// Edge that samples req in IDLE.
		@(posedge clock);
		cycles = 0;
		ack_seen = 1'b0;
		while (!ack_seen && cycles < ACK_LIMIT)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
			ack_seen = ack;
		end
		if (!ack_seen)
		begin
			$display("Vector %0d: ack never rose after req", vec);
			error_count++;
		end
		else if (cycles != ACK_CYCLES)
		begin
			$display("Vector %0d: ack rose after %0d clocks instead of %0d", vec, cycles,
				ACK_CYCLES);
			error_count++;
		end
		check_text_out(expected, vec);
		// Back-pressure for a random number of cycles.
		hold = $urandom % 8;
		repeat (hold)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			if (ack !== 1'b1)
			begin
				$display("Vector %0d: ack dropped while req was still held", vec);
				error_count++;
			end
			check_text_out(expected, vec);
		end
		req = 1'b0;
		@(posedge clock);
		#DRIVE_DELAY;
		if (ack !== 1'b0)
		begin
			$display("Vector %0d: ack still high one clock after req fell", vec);
			error_count++;
		end
		check_text_out(expected, vec);
	endtask

	// Stops a hung run.
	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("Watchdog expired after %0d clocks, run stopped", watchdog_cycles);
		$display("Summary: %0d vectors, %0d errors", vector_count, error_count + 1);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		data_in = '0;
		load_char = 1'b0;
		load_key = 1'b0;
		decode = 1'b0;
		method = METHOD_PASS;
		req = 1'b0;
		error_count = 0;
		text_pos_model = 0;
		watchdog_cycles = 0;
		seed = 32'h02bd947f;
		void'($urandom(seed));
		$readmemh("bench/cipher_stim.txt", stim_mem);
		// Unfilled entries stay unknown.
		vector_count = 0;
		while (vector_count < MAX_VECTORS && !$isunknown(stim_mem[FIELDS*vector_count]))
			vector_count++;
		watchdog_cycles = vector_count * 40 + 100;
		if (vector_count == 0)
		begin
			$display("No test vectors found in the stimulus file");
			error_count++;
		end
		// Idle state right after reset.
		wait (resetn === 1'b1);
		@(posedge clock);
		#DRIVE_DELAY;
		if (ack !== 1'b0)
		begin
			$display("FAIL after reset ack expected %h got %h", 1'b0, ack);
			error_count++;
		end
		check_text_out('0, -1);
		for (int v = 0; v < vector_count; v++)
		begin
			method = stim_mem[FIELDS*v][1:0];
			decode = stim_mem[FIELDS*v+1][0];
			load_vector(stim_mem[FIELDS*v+2][24:0], stim_mem[FIELDS*v+3][24:0],
				stim_mem[FIELDS*v+5][4:0]);
			run_and_check(stim_mem[FIELDS*v+4][24:0], v);
		end
		$display("Summary: %0d vectors, %0d errors", vector_count, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== all.f ====
common/cipher_pkg.sv
common/cipher_ctrl_if.sv
cipher/letter_shifter.sv
cipher/cipher_datapath.sv
cipher/cipher_sequencer.sv
hdl/text_loader.sv
hdl/cipher_top.sv
bench/tb_clock.sv
bench/cipher_tb.sv

// ==== bench/cipher_stim.txt ====
// Columns: method decode text key expected sixth, text values 25-bit hex with letter 1 on top.
// Sixth is a letter loaded after the text to wrap onto letter 1, 00 means none.
// Pass-through, codes 00 and 11.
0 0 082B18F 0110C85 082B18F 00
3 1 082B18F 1AD6B5A 082B18F 00
// Caesar shift by 'c', wrap past 'z' and 'a' with a blank.
1 0 0110C85 0308421 04298E8 00
1 0 18C8341 0308421 0110064 00
1 1 0110064 0308421 18C8341 00
// Caesar key 'z' leaves the text alone.
1 0 082B18F 1A18C63 082B18F 00
// Loader wrap puts 'j' into letter 1.
0 1 082B18F 0110C85 0A2B18F 0A
1 1 082B18F 1A18C63 082B18F 00
// Vigenere encode and decode back.
2 0 082B18F 0110C85 093BE14 00
2 1 093BE14 0110C85 082B18F 00
2 0 1A28A41 0C2B5EE 0C53CEF 00
2 1 0C53CEF 0C2B5EE 1A28A41 00
